// ==== dv/mdu_asserts.sv ====
`timescale 1ns/1ps

module mdu_asserts (
    input logic              clk,
    input logic              rst_n_i,
    input logic              flush_i,
    input logic              ready_o,
    input logic              valid_o,
    input logic              ready_i,
    input mdu_pkg::mdu_res_t res_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A stalled result stays put.
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (valid_o && !ready_i && !flush_i) |=> (valid_o && $stable(res_o)))
        else $error("valid_o or res_o changed while the result was held");

    // One operation at a time.
    a_single_op: assert property (@(posedge clk) disable iff (!rst_n_i)
        (valid_o && !ready_i) |-> !ready_o)
        else $error("ready_o high while an operation is still held");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Flush and reset
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_flush_kill: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !valid_o)
        else $error("valid_o high in the cycle after a flush");

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n_i |-> !valid_o)
        else $error("valid_o high during reset");

endmodule

// ==== dv/mdu_tb.sv ====
`timescale 1ns/1ps

module mdu_tb;
    import mdu_pkg::*;

    localparam logic [31:0] SEED = 32'h8461;
    localparam int NUM_RANDOM = 380;
    // Random ops plus corner and flush ops, at divider latency, with slack for stalls.
    localparam int TIMEOUT_CYCLES = (NUM_RANDOM + 20) * 34 * 3;

    typedef struct packed {
        mdu_op_e op;
        word_t   a;
        word_t   b;
        word_t   word;
        tag_t    tag;
    } exp_t;

    logic     clk = 1'b0;
    logic     rst_n_i;
    logic     flush_i;
    mdu_req_t req_i;
    logic     valid_i;
    logic     ready_o;
    mdu_res_t res_o;
    logic     valid_o;
    logic     ready_i;

    logic [31:0] stim_rng;
    logic [31:0] rdy_rng;
    int          ready_mode = 0;
    string       test_name = "reset";
    exp_t        exp_q[$];
    exp_t        exp_cur;
    mdu_op_e     cur_op;
    logic        hold_q = 1'b0;
    mdu_res_t    held_res;
    int          value_errs = 0;
    int          proto_errs = 0;
    int          n_results = 0;
    int          n_killed = 0;
    int          cycle_cnt = 0;
    int          corner_tag = 0;

    mdu DUT (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .req_i   (req_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .res_o   (res_o),
        .valid_o (valid_o),
        .ready_i (ready_i)
    );

    bind mdu mdu_asserts u_asserts (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .ready_o (ready_o),
        .valid_o (valid_o),
        .ready_i (ready_i),
        .res_o   (res_o)
    );

    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random numbers and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_stim();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    // Biased toward zero, minus one, one and the most negative value.
    function word_t pick_operand();
        logic [31:0] r;
        word_t       v;
        r = next_stim();
        case (r[3:0])
            4'd0: v = '0;
            4'd1: v = '1;
            4'd2: v = 32'h8000_0000;
            4'd3: v = 32'h0000_0001;
            default: v = next_stim();
        endcase
        return v;
    endfunction

    function automatic word_t ref_word(input mdu_op_e op, input word_t a, input word_t b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [63:0] sprod;
        logic        [63:0] uprod;
        logic               by_zero;
        logic               ovf;
        word_t              r;
        sa      = a;
        sb      = b;
        sprod   = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        uprod   = {32'd0, a} * {32'd0, b};
        by_zero = (b == '0);
        ovf     = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        r       = '0;
        case (op)
            MUL:   r = uprod[31:0];
            MULH:  r = sprod[63:32];
            MULHU: r = uprod[63:32];
            DIV: begin
                if (by_zero) r = '1;
                else if (ovf) r = a;
                else r = sa / sb;
            end
            REM: begin
                if (by_zero) r = a;
                else if (ovf) r = '0;
                else r = sa % sb;
            end
            DIVU:  r = by_zero ? '1 : a / b;
            REMU:  r = by_zero ? a : a % b;
            default: r = '0;
        endcase
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Mode 0 always ready, 1 random, 2 stalled.
    initial begin
        ready_i = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            rdy_rng = xorshift32(rdy_rng);
            ready_i = (ready_mode == 0) || ((ready_mode == 1) && (rdy_rng[1:0] != 2'd0));
        end
    end

    task idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task send(input mdu_op_e op, input word_t a, input word_t b, input tag_t tag);
        logic took;
        req_i   = {op, a, b, tag};
        valid_i = 1'b1;
        took    = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = ready_o;
            @(posedge clk);
            #1;
        end
        valid_i = 1'b0;
    endtask

    task corner(input mdu_op_e op, input word_t a, input word_t b);
        send(op, a, b, tag_t'(corner_tag));
        corner_tag++;
    endtask

    task pulse_flush();
        flush_i = 1'b1;
        @(posedge clk);
        #1;
        flush_i = 1'b0;
    endtask

    // The next request already waits at the input during the flush.
    task flush_and_send(input mdu_op_e op, input word_t a, input word_t b, input tag_t tag);
        req_i   = {op, a, b, tag};
        valid_i = 1'b1;
        pulse_flush();
        send(op, a, b, tag);
    endtask

    task set_ready_mode(input int m);
        @(negedge clk);
        ready_mode = m;
        @(posedge clk);
        #1;
    endtask

    task drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Monitor and scoreboard
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task check_result();
        if (exp_q.size() == 0) begin
            proto_errs++;
            $display("Result %h with tag %h arrived with no request outstanding",
                     res_o.word, res_o.tag);
        end else begin
            exp_cur = exp_q.pop_front();
            cur_op  = exp_cur.op;
            n_results++;
            if (res_o.word !== exp_cur.word) begin
                value_errs++;
                $display("CHECK FAILED %s %s a=%h b=%h word: expected %h actual %h", test_name,
                         cur_op.name(), exp_cur.a, exp_cur.b, exp_cur.word, res_o.word);
            end
            if (res_o.tag !== exp_cur.tag) begin
                value_errs++;
                $display("CHECK FAILED %s %s tag: expected %h actual %h", test_name,
                         cur_op.name(), exp_cur.tag, res_o.tag);
            end
        end
    endtask

    // Sampled mid-cycle, where inputs and outputs are settled for the coming edge.
    always @(negedge clk) begin
        if (!rst_n_i) begin
            if (valid_o) begin
                proto_errs++;
                $display("valid_o is high during reset at %0t", $time);
            end
            hold_q = 1'b0;
        end else begin
            if (hold_q && (!valid_o || (res_o !== held_res))) begin
                proto_errs++;
                $display("A held result was dropped or changed at %0t", $time);
            end
            if (flush_i) begin
                if (valid_i && ready_o) begin
                    proto_errs++;
                    $display("A request was accepted during a flush at %0t", $time);
                end
                n_killed += exp_q.size();
                exp_q.delete();
                hold_q = 1'b0;
            end else begin
                if (valid_o && ready_i) begin
                    check_result();
                end
                if (valid_i && ready_o) begin
                    if (exp_q.size() != 0) begin
                        proto_errs++;
                        $display("A second request was accepted before the first result left, at %0t",
                                 $time);
                    end
                    exp_cur.op   = req_i.op;
                    exp_cur.a    = req_i.a;
                    exp_cur.b    = req_i.b;
                    exp_cur.word = ref_word(req_i.op, req_i.a, req_i.b);
                    exp_cur.tag  = req_i.tag;
                    exp_q.push_back(exp_cur);
                end
                hold_q   = valid_o && !ready_i;
                held_res = res_o;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, the DUT appears to hang", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] r;
        mdu_op_e     op;
        word_t       a;
        word_t       b;
        rst_n_i  = 1'b0;
        flush_i  = 1'b0;
        valid_i  = 1'b0;
        req_i    = '0;
        stim_rng = SEED;
        rdy_rng  = ~SEED;
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        if (!ready_o || valid_o) begin
            proto_errs++;
            $display("After reset ready_o is %b and valid_o is %b, expected 1 and 0",
                     ready_o, valid_o);
        end
        @(posedge clk);
        #1;

        test_name = "corner";
        corner(DIV, 32'h8000_0000, 32'hffff_ffff);
        corner(REM, 32'h8000_0000, 32'hffff_ffff);
        corner(DIV, 32'h1234_5678, 32'h0);
        corner(REM, 32'h1234_5678, 32'h0);
        corner(DIVU, 32'hdead_beef, 32'h0);
        corner(REMU, 32'hdead_beef, 32'h0);
        corner(DIV, 32'hffff_fff9, 32'd2);
        corner(REM, 32'hffff_fff9, 32'd2);
        corner(REM, 32'd7, 32'hffff_fffe);
        corner(MULH, 32'hffff_ffff, 32'hffff_ffff);
        corner(MULH, 32'h8000_0000, 32'h8000_0000);
        corner(MULH, 32'hffff_fffd, 32'd5);
        corner(MULHU, 32'hffff_ffff, 32'hffff_ffff);
        corner(MUL, 32'hffff_ffff, 32'hffff_ffff);
        drain();

        test_name = "random";
        set_ready_mode(1);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = next_stim();
            idle((r[1:0] == 2'd0) ? int'(r[3:2]) : 0);
            op = mdu_op_e'(next_stim() % 7);
            a  = pick_operand();
            b  = pick_operand();
            send(op, a, b, tag_t'(next_stim()));
        end
        drain();
        set_ready_mode(0);

        // Kill a divide mid-iteration, a multiply in each stage, a held result.
        test_name = "flush";
        send(DIV, 32'h7fff_1234, 32'h0000_0013, 6'h21);
        idle(10);
        pulse_flush();
        send(DIVU, 32'd1000, 32'd7, 6'h22);
        drain();
        send(MULHU, 32'hffff_ffff, 32'hffff_ffff, 6'h23);
        flush_and_send(MULH, 32'h8000_0000, 32'h0000_0003, 6'h24);
        idle(1);
        pulse_flush();
        send(MUL, 32'h0001_0003, 32'h0000_0005, 6'h25);
        drain();
        set_ready_mode(2);
        send(REM, 32'hffff_fff9, 32'd2, 6'h26);
        idle(40);
        pulse_flush();
        set_ready_mode(0);
        send(DIV, 32'hffff_ff00, 32'h0000_0010, 6'h27);
        drain();
        if (n_killed != 4) begin
            proto_errs++;
            $display("Flush killed %0d operations where 4 were in flight", n_killed);
        end
        idle(5);

        $display("Results checked %0d, killed %0d, value errors %0d, other errors %0d",
                 n_results, n_killed, value_errs, proto_errs);
        if ((value_errs + proto_errs) == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== mdu.f ====
src/mdu_pkg.sv
src/mdu_muler.sv
src/mdu_diver.sv
src/mdu.sv
dv/mdu_asserts.sv
dv/mdu_tb.sv

// ==== src/mdu.sv ====
`timescale 1ns/1ps

module mdu (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              flush_i,

    input  mdu_pkg::mdu_req_t req_i,
    input  logic              valid_i,
    output logic              ready_o,

    output mdu_pkg::mdu_res_t res_o,
    output logic              valid_o,
    input  logic              ready_i
);
    import mdu_pkg::*;

    // Engine side.
    mdu_res_t mul_res;
    mdu_res_t div_res;
    logic     mul_start;
    logic     div_start;
    logic     mul_valid;
    logic     div_valid;

    // Handshake and held operation.
    logic     req_is_mul;
    logic     held_is_mul;
    logic     accept;
    logic     xfer;
    logic     busy_q;
    mdu_op_e  op_q;
    tag_t     tag_q;
    word_t    res_word;

    function automatic logic is_mul_op(input mdu_op_e op);
        return (op == MUL) || (op == MULH) || (op == MULHU);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Issue side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign xfer    = valid_o && ready_i;
    // Idle, or the held result leaves this cycle. Nothing enters during a flush.
    assign ready_o = !flush_i && (!busy_q || xfer);
    assign accept  = valid_i && ready_o;

    assign req_is_mul = is_mul_op(req_i.op);
    assign mul_start  = accept && req_is_mul;
    assign div_start  = accept && !req_is_mul;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            op_q   <= MUL;
        end else if (flush_i) begin
            busy_q <= 1'b0;
            op_q   <= MUL;
        end else if (accept) begin
            busy_q <= 1'b1;
            op_q   <= req_i.op;
        end else if (xfer) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q <= req_i.tag;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Engines
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    mdu_muler u_muler (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .req_i   (req_i),
        .valid_i (mul_start),
        .res_o   (mul_res),
        .valid_o (mul_valid),
        .ready_i (ready_i)
    );

    mdu_diver u_diver (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .req_i   (req_i),
        .valid_i (div_start),
        .res_o   (div_res),
        .valid_o (div_valid),
        .ready_i (ready_i)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Engine chosen by the operation held since acceptance.
    assign held_is_mul = is_mul_op(op_q);
    assign valid_o     = held_is_mul ? mul_valid : div_valid;
    assign res_word    = held_is_mul ? mul_res.word : div_res.word;

    assign res_o = '{word: res_word, tag: tag_q};

endmodule

// ==== src/mdu_diver.sv ====
`timescale 1ns/1ps

module mdu_diver (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              flush_i,

    input  mdu_pkg::mdu_req_t req_i,
    input  logic              valid_i,

    output mdu_pkg::mdu_res_t res_o,
    output logic              valid_o,
    input  logic              ready_i
);
    import mdu_pkg::*;

    div_state_e           state_q;
    div_state_e           state_d;
    logic [DIV_CNT_W-1:0] cnt_q;
    logic                 last_step;
    logic                 load;

    // Request decode.
    logic                 is_signed;
    logic                 a_neg;
    logic                 b_neg;
    word_t                a_abs;
    word_t                b_abs;

    // Partial remainder and quotient pair, plus the divisor magnitude.
    word_t                quo_q;
    word_t                rem_q;
    word_t                dvs_q;
    logic          [32:0] rem_sh;
    logic          [33:0] diff;

    // Recorded at load for the fix-up cycle.
    word_t                dividend_q;
    logic                 neg_quo_q;
    logic                 neg_rem_q;
    logic                 zero_q;
    logic                 ovf_q;
    logic                 want_rem_q;

    word_t                quo_fix;
    word_t                rem_fix;
    word_t                fix_word;
    word_t                res_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand preparation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign is_signed = (req_i.op == DIV) || (req_i.op == REM);
    assign a_neg     = is_signed && req_i.a[31];
    assign b_neg     = is_signed && req_i.b[31];
    assign a_abs     = a_neg ? -req_i.a : req_i.a;
    assign b_abs     = b_neg ? -req_i.b : req_i.b;

    // A new divide may start as the previous result leaves DONE.
    assign load = valid_i && ((state_q == IDLE) || ((state_q == DONE) && ready_i));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign last_step = (cnt_q == DIV_CNT_W'(DIV_STEPS - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (load) begin
                    state_d = CALC;
                end
            end
            CALC: begin
                if (last_step) begin
                    state_d = FIX;
                end
            end
            FIX: begin
                state_d = DONE;
            end
            DONE: begin
                if (load) begin
                    state_d = CALC;
                end else if (ready_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (flush_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (load) begin
                cnt_q <= '0;
            end else if (state_q == CALC) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Restoring step and fix-up
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Shift in the next dividend bit, then trial subtract.
    assign rem_sh = {rem_q, quo_q[31]};
    assign diff   = {1'b0, rem_sh} - {2'b00, dvs_q};

    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    always_comb begin
        if (zero_q) begin
            fix_word = want_rem_q ? dividend_q : '1;
        end else if (ovf_q) begin
            fix_word = want_rem_q ? '0 : dividend_q;
        end else begin
            fix_word = want_rem_q ? rem_fix : quo_fix;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            quo_q      <= a_abs;
            dvs_q      <= b_abs;
            rem_q      <= '0;
            dividend_q <= req_i.a;
            neg_quo_q  <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;
            zero_q     <= (req_i.b == '0);
            ovf_q      <= is_signed && (req_i.a == 32'h8000_0000) && (req_i.b == '1);
            want_rem_q <= (req_i.op == REM) || (req_i.op == REMU);
        end else if (state_q == CALC) begin
            // Sign of the trial result decides the quotient bit.
            quo_q <= {quo_q[30:0], ~diff[33]};
            rem_q <= diff[33] ? rem_sh[31:0] : diff[31:0];
        end else if (state_q == FIX) begin
            res_q <= fix_word;
        end
    end

    assign res_o   = '{word: res_q, tag: '0};
    assign valid_o = (state_q == DONE);

endmodule

// ==== src/mdu_muler.sv ====
`timescale 1ns/1ps

module mdu_muler (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              flush_i,

    input  mdu_pkg::mdu_req_t req_i,
    input  logic              valid_i,

    output mdu_pkg::mdu_res_t res_o,
    output logic              valid_o,
    input  logic              ready_i
);
    import mdu_pkg::*;

    // Operands widened by one bit so one signed multiply covers both flavours.
    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [65:0] prod_full;
    logic               high_sel;

    // Stage 1 holds the full product.
    logic               s1_valid_q;
    logic        [63:0] s1_prod_q;
    logic               s1_high_q;
    logic               s1_ready;

    // Stage 2 holds the selected word.
    logic               s2_valid_q;
    word_t              s2_word_q;
    logic               s2_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 1 product
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Only MULH is signed x signed. MUL takes the low word, same either way.
    always_comb begin
        a_ext = {1'b0, req_i.a};
        b_ext = {1'b0, req_i.b};
        if (req_i.op == MULH) begin
            a_ext[32] = req_i.a[31];
            b_ext[32] = req_i.b[31];
        end
    end

    assign high_sel  = (req_i.op == MULH) || (req_i.op == MULHU);
    assign prod_full = a_ext * b_ext;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A stage moves when the one after it is empty or draining.
    assign s2_ready = !s2_valid_q || ready_i;
    assign s1_ready = !s1_valid_q || s2_ready;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid_q <= valid_i;
            end
            if (s2_ready) begin
                s2_valid_q <= s1_valid_q;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (s1_ready && valid_i) begin
            s1_prod_q <= prod_full[63:0];
            s1_high_q <= high_sel;
        end
        if (s2_ready && s1_valid_q) begin
            s2_word_q <= s1_high_q ? s1_prod_q[63:32] : s1_prod_q[31:0];
        end
    end

    // Tag is filled in by the unit top.
    assign res_o   = '{word: s2_word_q, tag: '0};
    assign valid_o = s2_valid_q;

endmodule

// ==== src/mdu_pkg.sv ====
package mdu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One architectural data word.
    typedef logic [31:0] word_t;

    // Result tag, returned unchanged to the issuing stage.
    typedef logic [5:0] tag_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Multiply class first, divide class after.
    typedef enum logic [2:0] {
        MUL   = 3'd0,
        MULH  = 3'd1,
        MULHU = 3'd2,
        DIV   = 3'd3,
        DIVU  = 3'd4,
        REM   = 3'd5,
        REMU  = 3'd6
    } mdu_op_e;

    // Request from the issue stage, 73 bits.
    typedef struct packed {
        mdu_op_e op;
        word_t   a;
        word_t   b;
        tag_t    tag;
    } mdu_req_t;

    // Result back to the pipeline, 38 bits.
    typedef struct packed {
        word_t word;
        tag_t  tag;
    } mdu_res_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Divider
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One quotient bit per step.
    localparam int unsigned DIV_STEPS = 32;

    // Wide enough to count up to DIV_STEPS.
    localparam int unsigned DIV_CNT_W = 6;

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        FIX,
        DONE
    } div_state_e;

endpackage
